// ==== data_ram.sv ====
`default_nettype none

module data_ram #(
    parameter int ram_words   = 256,
    parameter int ram_latency = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ar_valid,
    input  logic [rv_load_pkg::addr_w-1:0] ar_addr,
    input  logic                           wr_en,
    input  logic [rv_load_pkg::addr_w-1:0] wr_addr,
    input  logic [rv_load_pkg::xlen-1:0]   wr_data,
    output logic                           ar_ready,
    output logic                           r_valid,
    output logic [rv_load_pkg::xlen-1:0]   r_data
);

    localparam int idx_w = $clog2(ram_words);
    localparam int lat_w = $clog2(ram_latency + 1);
    localparam logic [lat_w-1:0] lat_init = lat_w'(ram_latency);

    logic [rv_load_pkg::xlen-1:0] mem [ram_words];

    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] pend_idx;
    logic [lat_w-1:0] cnt;
    logic             pending;
    logic             hs;

    // doubleword index, bits above the index wrap around
    assign rd_idx = ar_addr[idx_w+2:3];
    assign wr_idx = wr_addr[idx_w+2:3];

    assign ar_ready = !pending;
    assign hs       = ar_valid && ar_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // word is fetched at the handshake and held until r_valid
    always_ff @(posedge clk) begin
        if (hs) begin
            r_data   <= mem[rd_idx];
            pend_idx <= rd_idx;
        end
    end

    // latency counter, r_valid fires ram_latency edges after hs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            cnt     <= '0;
            r_valid <= 1'b0;
        end else begin
            r_valid <= 1'b0;
            if (hs) begin
                pending <= 1'b1;
                cnt     <= lat_init;
            end else if (pending) begin
                cnt <= cnt - 1'b1;
                if (cnt == lat_w'(1)) begin
                    r_valid <= 1'b1;
                    pending <= 1'b0;
                end
            end
        end
    end

    // preload must not touch a word that is on its way out
    wr_pend_chk: assert property (@(posedge clk) disable iff (!rst_n)
        pending && wr_en |-> wr_idx != pend_idx)
        else $error("write to index %0d while its read is pending", wr_idx);

endmodule

`default_nettype wire

// ==== flist.f ====
rv_load_pkg.sv
load_fsm.sv
load_align.sv
mem_stage.sv
data_ram.sv
mem_subsys_top.sv
mem_checker.sv
tb_mem_subsys.sv

// ==== load_align.sv ====
`default_nettype none

module load_align (
    input  rv_load_pkg::load_type_e      load_type,
    input  logic [2:0]                   offset,
    input  logic [rv_load_pkg::xlen-1:0] raw_data,
    output logic [rv_load_pkg::xlen-1:0] aligned_data
);

    localparam int xlen = rv_load_pkg::xlen;

    rv_load_pkg::dword_view_u view;
    logic                     fill;
    logic [7:0]               byte_f;
    logic [15:0]              half_f;
    logic [31:0]              word_f;

    assign view = raw_data;

    // field at the offset, halves and words by their natural slot
    assign byte_f = view.b[offset];
    assign half_f = view.h[offset[2:1]];
    assign word_f = view.w[offset[2]];

    always_comb begin
        fill         = 1'b0;
        aligned_data = raw_data;
        case (load_type)
            rv_load_pkg::ld_b, rv_load_pkg::ld_bu: begin
                fill         = rv_load_pkg::load_signed(load_type) && byte_f[7];
                aligned_data = {{(xlen - 8){fill}}, byte_f};
            end
            rv_load_pkg::ld_h, rv_load_pkg::ld_hu: begin
                fill         = rv_load_pkg::load_signed(load_type) && half_f[15];
                aligned_data = {{(xlen - 16){fill}}, half_f};
            end
            rv_load_pkg::ld_w, rv_load_pkg::ld_wu: begin
                fill         = rv_load_pkg::load_signed(load_type) && word_f[31];
                aligned_data = {{(xlen - 32){fill}}, word_f};
            end
            default: begin
                // full doubleword, nothing to cut
                aligned_data = raw_data;
            end
        endcase
    end

    // natural alignment only, low offset bits below the size must be zero
    always_comb begin
        if (load_type != rv_load_pkg::ld_none) begin
            align_chk: assert final (
                (int'(offset) % rv_load_pkg::load_size(load_type)) == 0)
                else $error("misaligned load, type %s offset %0d",
                            load_type.name(), offset);
        end
    end

endmodule

`default_nettype wire

// ==== load_fsm.sv ====
`default_nettype none

module load_fsm (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv_load_pkg::load_type_e        load_type,
    input  logic [rv_load_pkg::addr_w-1:0] load_addr,
    input  logic                           ar_ready,
    input  logic                           r_valid,
    input  logic [rv_load_pkg::xlen-1:0]   r_data,
    output logic                           ar_valid,
    output logic [rv_load_pkg::addr_w-1:0] ar_addr,
    output logic                           mem_busy,
    output logic                           load_result_valid,
    output logic [rv_load_pkg::xlen-1:0]   load_data,
    output rv_load_pkg::load_type_e        held_type,
    output logic [2:0]                     held_offset
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req  = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       load_req;
    logic       accept;

    assign load_req = (load_type != rv_load_pkg::ld_none);
    // a load is only taken from idle, done ignores the still-held request
    assign accept   = (state == st_idle) && load_req;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (load_req) begin
                    state_nxt = st_req;
                end
            end
            st_req: begin
                // address handshake
                if (ar_ready) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (r_valid) begin
                    state_nxt = st_done;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            held_type   <= rv_load_pkg::ld_none;
            held_offset <= 3'd0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                held_type   <= load_type;
                held_offset <= load_addr[2:0];
            end
        end
    end

    // address and returned data
    always_ff @(posedge clk) begin
        if (accept) begin
            ar_addr <= load_addr;
        end
        if ((state == st_wait) && r_valid) begin
            load_data <= r_data;
        end
    end

    assign ar_valid          = (state == st_req);
    assign mem_busy          = (state == st_req) || (state == st_wait);
    assign load_result_valid = (state == st_done);

    // request must stay up and unchanged until the RAM takes it
    ar_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid dropped or ar_addr moved before ar_ready");

    // the RAM answers only the one request in flight
    r_wait_chk: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid |-> state == st_wait)
        else $error("r_valid outside of the wait state");

endmodule

`default_nettype wire

// ==== mem_checker.sv ====
`default_nettype none

module mem_checker #(
    parameter int ram_words   = 256,
    parameter int ram_latency = 3
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire rv_load_pkg::load_type_e load_type,
    input  wire logic [63:0]             src1,
    input  wire logic [63:0]             src2,
    input  wire logic [63:0]             ex_result,
    input  wire logic                    wr_en,
    input  wire logic [63:0]             wr_addr,
    input  wire logic [63:0]             wr_data,
    input  wire logic                    mem_busy,
    input  wire logic                    load_result_valid,
    input  wire logic [63:0]             wb_result
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int load_timeout = 50;

    logic [63:0] shadow [ram_words];

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int total_loads;

    initial begin
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        total_loads  = 0;
    end

    function automatic int word_index(logic [63:0] addr);
        return int'((addr >> 3) & 64'(ram_words - 1));
    endfunction

    // field at the byte offset extended to 64 bits by the load kind
    function automatic logic [63:0] expected_load(logic [63:0] dword, logic [2:0] offset,
                                                  rv_load_pkg::load_type_e t);
        int          nbits;
        logic        sext;
        logic [63:0] field;
        logic [63:0] mask;
        case (t)
            rv_load_pkg::ld_b, rv_load_pkg::ld_bu: nbits = 8;
            rv_load_pkg::ld_h, rv_load_pkg::ld_hu: nbits = 16;
            rv_load_pkg::ld_w, rv_load_pkg::ld_wu: nbits = 32;
            default:                               nbits = 64;
        endcase
        // only the narrow signed kinds replicate their top bit
        sext  = t inside {rv_load_pkg::ld_b, rv_load_pkg::ld_h, rv_load_pkg::ld_w};
        field = dword >> {offset, 3'b000};
        if (nbits == 64) begin
            return field;
        end
        mask  = (64'd1 << nbits) - 64'd1;
        field = field & mask;
        if (sext && field[nbits-1]) begin
            field = field | ~mask;
        end
        return field;
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        test_checks++;
        total_checks++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            note_error();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("totals: %0d loads, %0d checks, %0d errors", total_loads, total_checks,
                 total_errors);
    endtask

    // preload and rewrite traffic mirrored into the shadow
    always @(posedge clk) begin
        if (wr_en) begin
            shadow[word_index(wr_addr)] <= wr_data;
        end
    end

    initial begin
        int                      n;
        logic                    seen;
        logic [63:0]             addr;
        logic [63:0]             exp_val;
        rv_load_pkg::load_type_e t;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                check_value("wb_result", ex_result, wb_result);
                check_value("mem_busy", 64'd0, 64'(mem_busy));
                check_value("load_result_valid", 64'd0, 64'(load_result_valid));
                if (load_type != rv_load_pkg::ld_none) begin
                    addr    = src1 + src2;
                    t       = load_type;
                    exp_val = expected_load(shadow[word_index(addr)], addr[2:0], t);
                    seen    = 1'b0;
                    n       = 0;
                    while (!seen && n < load_timeout) begin
                        @(posedge clk);
                        n++;
                        if (load_result_valid) begin
                            seen = 1'b1;
                            total_loads++;
                            check_value("latency", 64'(ram_latency + 3), 64'(n));
                            check_value("wb_result", exp_val, wb_result);
                            check_value("mem_busy", 64'd0, 64'(mem_busy));
                        end else begin
                            check_value("mem_busy", 64'd1, 64'(mem_busy));
                            check_value("wb_result", ex_result, wb_result);
                        end
                    end
                    if (!seen) begin
                        $display("ERROR at %0t: load of type %s at %h never completed",
                                 $time, t.name(), addr);
                        note_error();
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv_load_pkg::load_type_e        load_type,
    input  logic [rv_load_pkg::xlen-1:0]   src1,
    input  logic [rv_load_pkg::xlen-1:0]   src2,
    input  logic [rv_load_pkg::xlen-1:0]   ex_result,
    input  logic                           ar_ready,
    input  logic                           r_valid,
    input  logic [rv_load_pkg::xlen-1:0]   r_data,
    output logic                           ar_valid,
    output logic [rv_load_pkg::addr_w-1:0] ar_addr,
    output logic                           mem_busy,
    output logic                           load_result_valid,
    output logic [rv_load_pkg::xlen-1:0]   wb_result
);

    logic [rv_load_pkg::addr_w-1:0] load_addr;
    logic [rv_load_pkg::xlen-1:0]   load_data;
    logic [rv_load_pkg::xlen-1:0]   aligned_data;
    rv_load_pkg::load_type_e        held_type;
    logic [2:0]                     held_offset;

    // effective address, base plus offset from execute
    assign load_addr = src1 + src2;

    load_fsm u_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_type         (load_type),
        .load_addr         (load_addr),
        .ar_ready          (ar_ready),
        .r_valid           (r_valid),
        .r_data            (r_data),
        .ar_valid          (ar_valid),
        .ar_addr           (ar_addr),
        .mem_busy          (mem_busy),
        .load_result_valid (load_result_valid),
        .load_data         (load_data),
        .held_type         (held_type),
        .held_offset       (held_offset)
    );

    // works on the held copy so the pipeline side may move on
    load_align u_align (
        .load_type    (held_type),
        .offset       (held_offset),
        .raw_data     (load_data),
        .aligned_data (aligned_data)
    );

    // writeback mux, load data only in the result cycle
    assign wb_result = load_result_valid ? aligned_data : ex_result;

endmodule

`default_nettype wire

// ==== mem_subsys_top.sv ====
`default_nettype none

module mem_subsys_top #(
    parameter int ram_words   = 256,
    parameter int ram_latency = 3
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv_load_pkg::load_type_e        load_type,
    input  logic [rv_load_pkg::xlen-1:0]   src1,
    input  logic [rv_load_pkg::xlen-1:0]   src2,
    input  logic [rv_load_pkg::xlen-1:0]   ex_result,
    input  logic                           wr_en,
    input  logic [rv_load_pkg::addr_w-1:0] wr_addr,
    input  logic [rv_load_pkg::xlen-1:0]   wr_data,
    output logic                           mem_busy,
    output logic                           load_result_valid,
    output logic [rv_load_pkg::xlen-1:0]   wb_result
);

    // read channel between stage and RAM
    logic                           ar_valid;
    logic                           ar_ready;
    logic [rv_load_pkg::addr_w-1:0] ar_addr;
    logic                           r_valid;
    logic [rv_load_pkg::xlen-1:0]   r_data;

    mem_stage u_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_type         (load_type),
        .src1              (src1),
        .src2              (src2),
        .ex_result         (ex_result),
        .ar_ready          (ar_ready),
        .r_valid           (r_valid),
        .r_data            (r_data),
        .ar_valid          (ar_valid),
        .ar_addr           (ar_addr),
        .mem_busy          (mem_busy),
        .load_result_valid (load_result_valid),
        .wb_result         (wb_result)
    );

    data_ram #(
        .ram_words   (ram_words),
        .ram_latency (ram_latency)
    ) u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_mem_subsys \
    -f flist.f \
    -o sim_mem_subsys

./obj_dir/sim_mem_subsys > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== rv_load_pkg.sv ====
`default_nettype none

package rv_load_pkg;

    localparam int xlen   = 64;
    localparam int addr_w = 64;

    // load kinds decoded from the instruction, ld_none for everything else
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1,
        ld_h    = 3'd2,
        ld_w    = 3'd3,
        ld_d    = 3'd4,
        ld_bu   = 3'd5,
        ld_hu   = 3'd6,
        ld_wu   = 3'd7
    } load_type_e;

    // one read doubleword seen as bytes, halves or words
    typedef union packed {
        logic [xlen/8-1:0][7:0]   b;
        logic [xlen/16-1:0][15:0] h;
        logic [xlen/32-1:0][31:0] w;
    } dword_view_u;

    // access size in bytes, 0 when not a load
    function automatic int unsigned load_size(load_type_e t);
        case (t)
            ld_b, ld_bu: return 1;
            ld_h, ld_hu: return 2;
            ld_w, ld_wu: return 4;
            ld_d:        return 8;
            default:     return 0;
        endcase
    endfunction

    // signed loads replicate the top bit of the field
    function automatic logic load_signed(load_type_e t);
        return (t == ld_b) || (t == ld_h) || (t == ld_w) || (t == ld_d);
    endfunction

endpackage

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`default_nettype none

module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ram_words   = 256;
    localparam int ram_latency = 3;
    localparam int seed        = 32'h4761d072;
    // outlasts the checker's own load timeout
    localparam int tb_timeout  = 60;

    logic                    clk;
    logic                    rst_n;
    rv_load_pkg::load_type_e load_type;
    logic [63:0]             src1;
    logic [63:0]             src2;
    logic [63:0]             ex_result;
    logic                    wr_en;
    logic [63:0]             wr_addr;
    logic [63:0]             wr_data;
    logic                    mem_busy;
    logic                    load_result_valid;
    logic [63:0]             wb_result;
    int                      loads_issued;
    logic                    load_hung;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    mem_subsys_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_type         (load_type),
        .src1              (src1),
        .src2              (src2),
        .ex_result         (ex_result),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .mem_busy          (mem_busy),
        .load_result_valid (load_result_valid),
        .wb_result         (wb_result)
    );

    mem_checker #(
        .ram_words   (ram_words),
        .ram_latency (ram_latency)
    ) u_chk (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_type         (load_type),
        .src1              (src1),
        .src2              (src2),
        .ex_result         (ex_result),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .mem_busy          (mem_busy),
        .load_result_valid (load_result_valid),
        .wb_result         (wb_result)
    );

    function automatic logic [63:0] random_dword();
        return {$urandom, $urandom};
    endfunction

    task automatic drive_idle();
        @(negedge clk);
        load_type = rv_load_pkg::ld_none;
        src1      = random_dword();
        src2      = random_dword();
        ex_result = random_dword();
    endtask

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    // present a load and hold it until the result cycle
    task automatic run_load(input rv_load_pkg::load_type_e t, input logic [63:0] addr);
        int   n;
        logic got;
        @(negedge clk);
        load_type = t;
        src1      = random_dword();
        src2      = addr - src1;
        ex_result = random_dword();
        loads_issued++;
        got = 1'b0;
        n   = 0;
        while (!got && n < tb_timeout) begin
            @(negedge clk);
            got = load_result_valid;
            n++;
        end
        if (!got) begin
            $display("timeout: no load result after %0d cycles", tb_timeout);
            load_hung = 1'b1;
        end else begin
            load_type = rv_load_pkg::ld_none;
            ex_result = random_dword();
        end
    endtask

    task automatic random_load();
        rv_load_pkg::load_type_e t;
        int unsigned             size;
        logic [63:0]             addr;
        t    = rv_load_pkg::load_type_e'(3'(1 + $urandom % 7));
        size = rv_load_pkg::load_size(t);
        addr = random_dword();
        addr[2:0] = 3'(($urandom % (8 / size)) * size);
        run_load(t, addr);
    endtask

    initial begin
        int                      ti;
        int                      off;
        logic [63:0]             addr;
        rv_load_pkg::load_type_e t;
        void'($urandom(seed));
        rst_n        = 1'b0;
        load_type    = rv_load_pkg::ld_none;
        src1         = '0;
        src2         = '0;
        ex_result    = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        loads_issued = 0;
        load_hung    = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (5) drive_idle();
        u_chk.end_test("reset");

        for (int i = 0; i < ram_words; i++) begin
            write_word(64'(i) << 3, random_dword());
        end
        repeat (50) drive_idle();
        u_chk.end_test("pass_through");

        for (ti = 1; ti < 8; ti++) begin
            t = rv_load_pkg::load_type_e'(3'(ti));
            for (off = 0; off < 8; off += int'(rv_load_pkg::load_size(t))) begin
                repeat (3) begin
                    addr      = random_dword();
                    addr[2:0] = 3'(off);
                    run_load(t, addr);
                end
            end
        end
        u_chk.end_test("all_types_offsets");

        // loads separated by idle gaps
        repeat (10) begin
            random_load();
            repeat (3) drive_idle();
        end
        u_chk.end_test("stall_latency");

        repeat (200) random_load();
        u_chk.end_test("back_to_back");

        addr      = random_dword();
        addr[2:0] = 3'd0;
        run_load(rv_load_pkg::ld_d, addr);
        write_word(addr, ~random_dword());
        run_load(rv_load_pkg::ld_d, addr);
        repeat (5) drive_idle();
        u_chk.end_test("rewrite");

        u_chk.print_totals();
        if (!load_hung && u_chk.total_errors == 0 && u_chk.total_loads == loads_issued) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("loads issued %0d, completed %0d", loads_issued, u_chk.total_loads);
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
